/* run_sim.sh */
#!/bin/sh
# build and run the scratchpad testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mac_scratchpad \
    --Mdir obj_dir \
    -f sources.f

# a fatal stop leaves a nonzero status, the search below decides
out=$(./obj_dir/Vtb_mac_scratchpad 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "TESTS PASSED"

/* sources.f */
+incdir+testbench
src/mac_sp_pkg.sv
src/sram_1rw_32x128.sv
src/mem_sp_banked.sv
src/mac_dot_engine.sv
src/wb_scratchpad_port.sv
src/mac_scratchpad_top.sv
testbench/tb_mac_scratchpad.sv

/* src/mac_dot_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_dot_engine (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [mac_sp_pkg::row_addr_width-1:0] row_a,
    input  logic [mac_sp_pkg::row_addr_width-1:0] row_b,
    input  logic [mac_sp_pkg::row_width-1:0]      mem_rdata,
    output logic [mac_sp_pkg::row_addr_width-1:0] mem_addr,
    output logic                                  mem_ren,
    output logic                                  busy,
    output logic [mac_sp_pkg::acc_width-1:0]      result
);

    import mac_sp_pkg::*;

    // two back-to-back reads then two captures
    typedef enum logic [2:0] {
        st_idle,
        st_rd_a,
        st_rd_b,
        st_cap_a,
        st_cap_b,
        st_calc,
        st_done
    } state_t;

    state_t state;
    logic [row_addr_width-1:0] row_a_q;
    logic [row_addr_width-1:0] row_b_q;
    logic [row_width-1:0] lanes_a;
    logic [row_width-1:0] lanes_b;
    logic signed [acc_width-1:0] dot_sum;

    // sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            result <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_rd_a;
                    end
                end
                st_rd_a: state <= st_rd_b;
                st_rd_b: state <= st_cap_a;
                // row a arrives two cycles after its request
                st_cap_a: state <= st_cap_b;
                st_cap_b: state <= st_calc;
                st_calc: begin
                    result <= dot_sum;
                    state <= st_done;
                end
                // result already stable while busy drops
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            row_a_q <= row_a;
            row_b_q <= row_b;
        end
        if (state == st_cap_a) begin
            lanes_a <= mem_rdata;
        end
        if (state == st_cap_b) begin
            lanes_b <= mem_rdata;
        end
    end

    // sum of eight signed 8x8 products
    always_comb begin
        logic signed [acc_width-1:0] prod;
        dot_sum = '0;
        for (int i = 0; i < mac_mult_num; i++) begin
            // lanes sign-extend to the sum width before the multiply
            prod = acc_width'($signed(lanes_a[i*idata_width +: idata_width]))
                 * acc_width'($signed(lanes_b[i*idata_width +: idata_width]));
            dot_sum = dot_sum + prod;
        end
    end

    // memory request that the port forwards while busy
    assign mem_ren = (state == st_rd_a) || (state == st_rd_b);
    assign mem_addr = (state == st_rd_b) ? row_b_q : row_a_q;
    assign busy = (state != st_idle);

    // port must drop starts that arrive mid-computation
    a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n) !(start && busy))
        else $error("mac_dot_engine: start while busy");

endmodule

`default_nettype wire

/* src/mac_scratchpad_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_scratchpad_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [mac_sp_pkg::wb_adr_width-1:0]  wb_adr,
    input  logic [mac_sp_pkg::macro_width-1:0]   wb_dat_w,
    input  logic [mac_sp_pkg::macro_width/8-1:0] wb_sel,
    output logic [mac_sp_pkg::macro_width-1:0]   wb_dat_r,
    output logic                                 wb_ack
);

    import mac_sp_pkg::*;

    // shared memory port
    logic [row_addr_width-1:0] mem_addr;
    logic mem_wen;
    logic [num_banks-1:0] mem_bwe;
    logic [row_width-1:0] mem_wdata;
    logic mem_ren;
    logic [row_width-1:0] mem_rdata;

    // engine control and its own request
    logic eng_start;
    logic [row_addr_width-1:0] eng_row_a;
    logic [row_addr_width-1:0] eng_row_b;
    logic eng_busy;
    logic [row_addr_width-1:0] eng_mem_addr;
    logic eng_mem_ren;
    logic [acc_width-1:0] eng_result;

    wb_scratchpad_port i_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_wen      (mem_wen),
        .mem_bwe      (mem_bwe),
        .mem_wdata    (mem_wdata),
        .mem_ren      (mem_ren),
        .eng_busy     (eng_busy),
        .eng_mem_addr (eng_mem_addr),
        .eng_mem_ren  (eng_mem_ren),
        .eng_result   (eng_result),
        .eng_start    (eng_start),
        .eng_row_a    (eng_row_a),
        .eng_row_b    (eng_row_b)
    );

    mac_dot_engine i_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (eng_start),
        .row_a     (eng_row_a),
        .row_b     (eng_row_b),
        .mem_rdata (mem_rdata),
        .mem_addr  (eng_mem_addr),
        .mem_ren   (eng_mem_ren),
        .busy      (eng_busy),
        .result    (eng_result)
    );

    // two tiles deep, two banks wide
    mem_sp_banked #(
        .DEPTH (sp_depth)
    ) i_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wen   (mem_wen),
        .bwe   (mem_bwe),
        .wdata (mem_wdata),
        .ren   (mem_ren),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* src/mac_sp_pkg.sv */
`default_nettype none

package mac_sp_pkg;

    // lane geometry of the mac array
    localparam int idata_width = 8;
    localparam int mac_mult_num = 8;

    // one scratchpad row holds a full operand vector
    localparam int row_width = idata_width * mac_mult_num;

    // single-port macro shape
    localparam int macro_width = 32;
    localparam int macro_depth = 128;

    // macros side by side across a row
    localparam int num_banks = row_width / macro_width;

    // rows in the scratchpad, two tiles deep
    localparam int sp_depth = 256;
    localparam int row_addr_width = $clog2(sp_depth);

    // bus word address
    // bit 9 picks registers, 8:1 row, 0 bank
    localparam int wb_adr_width = 10;

    // signed dot-product sum
    localparam int acc_width = 32;

    // register offsets, low two address bits
    localparam logic [1:0] reg_ctrl_ofs = 2'd0;
    localparam logic [1:0] reg_result_ofs = 2'd1;
    localparam logic [1:0] reg_status_ofs = 2'd2;

endpackage

`default_nettype wire

/* src/mem_sp_banked.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_sp_banked #(
    // rows, a whole number of macro depths
    parameter int DEPTH = 128
) (
    input  logic                               clk,
    input  logic [$clog2(DEPTH)-1:0]           addr,
    // active-high write enable
    input  logic                               wen,
    // one write enable per bank
    input  logic [mac_sp_pkg::num_banks-1:0]   bwe,
    input  logic [mac_sp_pkg::row_width-1:0]   wdata,
    // active-high read enable
    input  logic                               ren,
    output logic [mac_sp_pkg::row_width-1:0]   rdata
);

    import mac_sp_pkg::*;

    localparam int num_tiles = DEPTH / macro_depth;
    localparam int local_bits = $clog2(macro_depth);
    // keep at least one select bit for a single tile
    localparam int sel_bits = (num_tiles > 1) ? $clog2(num_tiles) : 1;

    logic [local_bits-1:0] local_addr;
    logic [sel_bits-1:0] tile_sel;
    logic [sel_bits-1:0] tile_sel_q;
    logic ren_q;
    logic [num_tiles-1:0][row_width-1:0] tile_rdata;

    // low bits address inside a macro
    assign local_addr = addr[local_bits-1:0];
    // upper bits pick the tile, zero for a one-tile memory
    assign tile_sel = sel_bits'(addr >> local_bits);

    for (genvar t = 0; t < num_tiles; t++) begin : g_tile
        for (genvar b = 0; b < num_banks; b++) begin : g_bank
            logic bank_we;
            logic csb;
            logic web;

            // bank written only with its own enable
            assign bank_we = wen && bwe[b];
            // macro wakes up for a read or for its own write
            assign csb = !((tile_sel == sel_bits'(t)) && (ren || bank_we));
            assign web = !bank_we;

            sram_1rw_32x128 i_macro (
                .clk  (clk),
                .csb  (csb),
                .web  (web),
                .addr (local_addr),
                .din  (wdata[b*macro_width +: macro_width]),
                .dout (tile_rdata[t][b*macro_width +: macro_width])
            );
        end
    end

    // remember which tile a read went to
    always_ff @(posedge clk) begin
        ren_q <= ren;
        tile_sel_q <= tile_sel;
    end

    // output register, one cycle behind the macro latch
    // zeros unless a read was issued the cycle before
    always_ff @(posedge clk) begin
        if (ren_q) begin
            rdata <= tile_rdata[tile_sel_q];
        end else begin
            rdata <= '0;
        end
    end

    // host and engine share one port, never read and write at once
    a_no_rw_collision : assert property (@(posedge clk) !(wen && ren))
        else $error("mem_sp_banked: wen and ren high together");

endmodule

`default_nettype wire

/* src/sram_1rw_32x128.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_1rw_32x128 (
    input  logic        clk,
    // active-low chip select
    input  logic        csb,
    // active-low write strobe
    input  logic        web,
    input  logic [6:0]  addr,
    input  logic [31:0] din,
    output logic [31:0] dout
);

    import mac_sp_pkg::*;

    // storage array, same shape as the foundry macro
    logic [macro_width-1:0] mem [macro_depth];

    // one access per cycle
    // write when web low, read when web high
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[addr] <= din;
            end else begin
                // read word lands in the macro output latch
                dout <= mem[addr];
            end
        end
        // deselected: dout keeps its last value
    end

endmodule

`default_nettype wire

/* src/wb_scratchpad_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_scratchpad_port (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [mac_sp_pkg::wb_adr_width-1:0]   wb_adr,
    input  logic [mac_sp_pkg::macro_width-1:0]    wb_dat_w,
    input  logic [mac_sp_pkg::macro_width/8-1:0]  wb_sel,
    output logic [mac_sp_pkg::macro_width-1:0]    wb_dat_r,
    output logic                                  wb_ack,
    input  logic [mac_sp_pkg::row_width-1:0]      mem_rdata,
    output logic [mac_sp_pkg::row_addr_width-1:0] mem_addr,
    output logic                                  mem_wen,
    output logic [mac_sp_pkg::num_banks-1:0]      mem_bwe,
    output logic [mac_sp_pkg::row_width-1:0]      mem_wdata,
    output logic                                  mem_ren,
    input  logic                                  eng_busy,
    input  logic [mac_sp_pkg::row_addr_width-1:0] eng_mem_addr,
    input  logic                                  eng_mem_ren,
    input  logic [mac_sp_pkg::acc_width-1:0]      eng_result,
    output logic                                  eng_start,
    output logic [mac_sp_pkg::row_addr_width-1:0] eng_row_a,
    output logic [mac_sp_pkg::row_addr_width-1:0] eng_row_b
);

    import mac_sp_pkg::*;

    // read latency counter
    typedef enum logic [1:0] {
        st_idle,
        st_rd_wait,
        st_rd_data
    } state_t;

    state_t state;
    logic req;
    logic is_mem;
    logic host_wr;
    logic host_rd;
    logic reg_acc;
    logic start_req;
    logic [row_addr_width-1:0] host_row;
    logic bank;
    logic [num_banks-1:0] bank_sel;
    logic [macro_width-1:0] reg_rdata;

    // a new access and not the tail of the one just acked
    assign req = wb_cyc && wb_stb && !wb_ack && (state == st_idle);
    assign is_mem = !wb_adr[wb_adr_width-1];
    assign host_row = wb_adr[row_addr_width:1];
    assign bank = wb_adr[0];

    // memory traffic waits out the engine
    assign host_wr = req && is_mem && wb_we && !eng_busy;
    assign host_rd = req && is_mem && !wb_we && !eng_busy;
    // register space never stalls so status stays pollable
    assign reg_acc = req && !is_mem;
    assign start_req = reg_acc && wb_we && (wb_adr[1:0] == reg_ctrl_ofs)
                     && wb_dat_w[2*row_addr_width] && !eng_busy;

    // a partial or zero sel writes nothing
    always_comb begin
        bank_sel = '0;
        if (&wb_sel) begin
            bank_sel[bank] = 1'b1;
        end
    end

    // register read mux
    always_comb begin
        case (wb_adr[1:0])
            reg_result_ofs: reg_rdata = eng_result;
            reg_status_ofs: reg_rdata = {{(macro_width-1){1'b0}}, eng_busy};
            default: reg_rdata = '0;
        endcase
    end

    // engine owns the memory port while busy
    assign mem_addr = eng_busy ? eng_mem_addr : host_row;
    assign mem_ren = eng_busy ? eng_mem_ren : host_rd;
    assign mem_wen = host_wr;
    assign mem_bwe = host_wr ? bank_sel : '0;
    // same word into every bank lane
    assign mem_wdata = {num_banks{wb_dat_w}};

    // handshake FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            wb_ack <= 1'b0;
            eng_start <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            eng_start <= start_req;
            case (state)
                st_idle: begin
                    if (reg_acc || host_wr) begin
                        wb_ack <= 1'b1;
                    end else if (host_rd) begin
                        state <= st_rd_wait;
                    end
                end
                // macro latch then output register
                st_rd_wait: state <= st_rd_data;
                st_rd_data: begin
                    wb_ack <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // return data and engine operands
    always_ff @(posedge clk) begin
        if (reg_acc) begin
            wb_dat_r <= reg_rdata;
        end
        if (state == st_rd_data) begin
            // bank 0 is the low half of the row
            wb_dat_r <= mem_rdata[int'(bank)*macro_width +: macro_width];
        end
        if (start_req) begin
            eng_row_a <= wb_dat_w[row_addr_width-1:0];
            eng_row_b <= wb_dat_w[2*row_addr_width-1:row_addr_width];
        end
    end

    a_ack_single : assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else $error("wb_scratchpad_port: ack held two cycles");

endmodule

`default_nettype wire

/* testbench/tb_wb_tasks.svh */
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// wishbone classic master, entered and left on a falling edge
// all master signals held until ack, ack sampled on falling edges
task automatic bus_cycle(
    input  logic                      we,
    input  logic [wb_adr_width-1:0]   adr,
    input  logic [macro_width-1:0]    wdat,
    input  logic [macro_width/8-1:0]  sel,
    output logic [macro_width-1:0]    rdat
);
    int waited;
    logic ack_seen;
    waited = 0;
    ack_seen = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    wb_sel = sel;
    // count rising edges until ack shows up
    while (!ack_seen && waited < ack_timeout) begin
        @(negedge clk);
        waited++;
        ack_seen = wb_ack;
    end
    if (!ack_seen) begin
        fail_run($sformatf("timeout: no ack within %0d cycles for address %h",
                           ack_timeout, adr));
    end
    rdat = wb_dat_r;
    last_latency = waited;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    // ack drops on the next edge, next access starts after that
    @(negedge clk);
endtask

task automatic write_word(
    input logic [wb_adr_width-1:0]   adr,
    input logic [macro_width-1:0]    data,
    input logic [macro_width/8-1:0]  sel
);
    logic [macro_width-1:0] ignored;
    bus_cycle(1'b1, adr, data, sel, ignored);
endtask

task automatic read_word(
    input  logic [wb_adr_width-1:0] adr,
    output logic [macro_width-1:0]  data
);
    bus_cycle(1'b0, adr, '0, '1, data);
endtask

`endif

/* testbench/tb_mac_scratchpad.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mac_scratchpad;

    import mac_sp_pkg::*;

    localparam int ack_timeout = 64;
    localparam int poll_limit = 40;
    localparam int num_rows = 8;
    localparam int num_pairs = 5;

    logic clk = 1'b0;
    logic rst_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [wb_adr_width-1:0] wb_adr;
    logic [macro_width-1:0] wb_dat_w;
    logic [macro_width/8-1:0] wb_sel;
    logic [macro_width-1:0] wb_dat_r;
    logic wb_ack;

    // cycles from stb to ack of the last access
    int last_latency;
    // expected contents, indexed by word address
    logic [macro_width-1:0] shadow [2*sp_depth];

    // stimulus table, rows and their lanes
    logic [row_addr_width-1:0] row_addr [num_rows];
    logic [row_width-1:0] row_lanes [num_rows];
    // dot-product pairs as row table indices
    int pair_a [num_pairs];
    int pair_b [num_pairs];
    int pair_sum [num_pairs];

    // 8 ns clock
    always #4 clk = ~clk;

    mac_scratchpad_top i_mac_scratchpad_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tb_wb_tasks.svh"

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("FAILED at %0t ns: %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    // signed lane rule, sum of eight 8x8 products
    function automatic int dot_expected(input logic [row_width-1:0] a,
                                        input logic [row_width-1:0] b);
        int sum;
        byte la;
        byte lb;
        sum = 0;
        for (int i = 0; i < mac_mult_num; i++) begin
            la = a[i*idata_width +: idata_width];
            lb = b[i*idata_width +: idata_width];
            sum += int'(la) * int'(lb);
        end
        return sum;
    endfunction

    // bit 9 low, row in 8:1, bank in 0
    function automatic logic [wb_adr_width-1:0] word_adr(input logic [7:0] row,
                                                         input logic bank);
        return {1'b0, row, bank};
    endfunction

    function automatic logic [wb_adr_width-1:0] reg_adr(input logic [1:0] ofs);
        return {1'b1, 7'd0, ofs};
    endfunction

    task automatic write_tracked(input logic [7:0] row, input logic bank,
                                 input logic [31:0] data);
        write_word(word_adr(row, bank), data, 4'hf);
        shadow[{row, bank}] = data;
    endtask

    task automatic read_check(input logic [7:0] row, input logic bank);
        logic [31:0] rd;
        read_word(word_adr(row, bank), rd);
        check_value($sformatf("row %0d bank %0d", row, bank), rd, shadow[{row, bank}]);
    endtask

    // control word, start in bit 16
    task automatic start_engine(input logic [7:0] ra, input logic [7:0] rb);
        write_word(reg_adr(reg_ctrl_ofs), {15'd0, 1'b1, rb, ra}, 4'hf);
    endtask

    // status polled until busy drops
    task automatic wait_engine_idle();
        logic [31:0] st;
        int polls;
        polls = 0;
        st = 32'd1;
        while (st[0] && polls < poll_limit) begin
            read_word(reg_adr(reg_status_ofs), st);
            polls++;
        end
        if (st[0]) begin
            fail_run("timeout: engine still busy after status polling");
        end
    endtask

    task automatic check_result(input int p, input string what);
        logic [31:0] rd;
        read_word(reg_adr(reg_result_ofs), rd);
        check_value(what, rd, 32'(pair_sum[p]));
    endtask

    initial begin
        logic [31:0] rd;
        void'($urandom(32'h129ff011));
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        last_latency = 0;

        // lanes listed lane 7 down to lane 0
        row_addr[0] = 8'd10;
        row_lanes[0] = 64'h8080_8080_8080_8080;
        row_addr[1] = 8'd11;
        row_lanes[1] = 64'h8080_8080_8080_8080;
        // -8 7 -6 5 -4 3 -2 1
        row_addr[2] = 8'd20;
        row_lanes[2] = 64'hF807_FA05_FC03_FE01;
        // 50 -100 100 0 2 -1 -128 127
        row_addr[3] = 8'd21;
        row_lanes[3] = 64'h329C_6400_02FF_807F;
        // second tile, random lanes
        row_addr[4] = 8'd130;
        row_lanes[4] = {$urandom(), $urandom()};
        row_addr[5] = 8'd250;
        row_lanes[5] = {$urandom(), $urandom()};
        row_addr[6] = 8'd3;
        row_lanes[6] = 64'h0102_0304_0506_0708;
        row_addr[7] = 8'd200;
        row_lanes[7] = 64'hFF7F_8001_FE02_10F0;
        pair_a = '{0, 2, 4, 6, 2};
        pair_b = '{1, 3, 5, 7, 0};
        for (int p = 0; p < num_pairs; p++) begin
            pair_sum[p] = dot_expected(row_lanes[pair_a[p]], row_lanes[pair_b[p]]);
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // register access on an idle bus acks after one cycle
        read_word(reg_adr(reg_status_ofs), rd);
        check_value("status after reset", rd, 32'd0);
        check_value("register ack latency", 32'(last_latency), 32'd1);
        read_word(reg_adr(reg_result_ofs), rd);
        check_value("result after reset", rd, 32'd0);

        // load every table row, both banks
        for (int r = 0; r < num_rows; r++) begin
            write_tracked(row_addr[r], 1'b0, row_lanes[r][31:0]);
            write_tracked(row_addr[r], 1'b1, row_lanes[r][63:32]);
        end
        check_value("memory write ack latency", 32'(last_latency), 32'd1);
        for (int r = 0; r < num_rows; r++) begin
            read_check(row_addr[r], 1'b0);
            read_check(row_addr[r], 1'b1);
        end
        check_value("memory read ack latency", 32'(last_latency), 32'd3);

        // dot product per table pair
        for (int p = 0; p < num_pairs; p++) begin
            start_engine(row_addr[pair_a[p]], row_addr[pair_b[p]]);
            wait_engine_idle();
            check_result(p, $sformatf("dot product pair %0d", p));
        end

        // host read stalls behind the engine, data and result intact
        start_engine(row_addr[pair_a[1]], row_addr[pair_b[1]]);
        read_check(row_addr[5], 1'b1);
        assert (last_latency > 3) else begin
            fail_run($sformatf("FAILED at %0t ns: read during busy acked after %0d cycles",
                               $time, last_latency));
        end
        wait_engine_idle();
        check_result(1, "result after stalled host read");

        // second start during busy is dropped
        start_engine(row_addr[pair_a[0]], row_addr[pair_b[0]]);
        start_engine(row_addr[pair_a[1]], row_addr[pair_b[1]]);
        wait_engine_idle();
        check_result(0, "result after start while busy");

        // last write wins
        write_tracked(8'd3, 1'b0, $urandom());
        read_check(8'd3, 1'b0);
        // bank 1 write leaves bank 0 alone
        write_tracked(8'd200, 1'b1, $urandom());
        read_check(8'd200, 1'b0);
        read_check(8'd200, 1'b1);
        // zero sel writes nothing
        write_word(word_adr(8'd200, 1'b0), $urandom(), 4'h0);
        read_check(8'd200, 1'b0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
